// ==== arb_top.f ====
hdl/arb_pkg.sv
hdl/payload_pkg.sv
hdl/rr_state.sv
hdl/pri_rr_arbiter.sv
hdl/grant_register.sv
hdl/arb_top.sv
bench/tb_clock.sv
bench/arb_checker.sv
bench/arb_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, then decide the result from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f arb_top.f --top-module arb_top_tb -o arb_top_sim \
  > build.log 2>&1 \
  && ./obj_dir/arb_top_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation aborted"; exit 1; }

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Run reported failure"; exit 1; }
echo "Run completed without failure"
exit 0

// ==== bench/arb_top_tb.sv ====
// Directed patterns assume four requesters, the reference model and random phase follow the packages
`timescale 1ns/1ps
`default_nettype none

module arb_top_tb;

  localparam int NR  = arb_pkg::NUM_REQUESTERS;
  localparam int PW  = arb_pkg::PRI_WIDTH;
  localparam int IW  = arb_pkg::IDX_WIDTH;
  localparam int DW  = payload_pkg::DATA_WIDTH;
  localparam int DBW = payload_pkg::DATA_BUS_WIDTH;

  localparam logic [31:0] RANDOM_SEED   = 32'h14c;
  localparam int          RESET_TIMEOUT = 20;
  localparam int          DRAIN_TIMEOUT = 20;
  localparam int          RANDOM_CYCLES = 400;

  logic             clk;
  logic             rst_n;
  logic             enable_priority_update;
  logic [NR-1:0]    request;
  logic [NR*PW-1:0] request_priority;
  logic [DBW-1:0]   request_data;
  logic             out_valid;
  logic [IW-1:0]    out_index;
  logic [DW-1:0]    out_data;

  // Mismatches seen by the compare process, other failures seen by stimulus
  int value_errors = 0;
  int setup_errors = 0;
  int check_count  = 0;
  int seed;

  // Model of which indices already had their round-robin turn
  logic [NR-1:0] model_mask;

  // One entry per driven cycle, consumed one edge later
  logic          exp_valid_q[$];
  logic [IW-1:0] exp_index_q[$];
  logic [DW-1:0] exp_data_q[$];
  string         exp_name_q[$];

  tb_clock i_tb_clock (
    .clk (clk)
  );

  arb_top i_dut (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .enable_priority_update (enable_priority_update),
    .request                (request),
    .request_priority       (request_priority),
    .request_data           (request_data),
    .out_valid              (out_valid),
    .out_index              (out_index),
    .out_data               (out_data)
  );

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------

  // Highest priority wins, ties go to the first index after the last
  // grant, scanning upward and wrapping. Result is {valid, index}
  function automatic logic [IW:0] expected_winner(input logic [NR-1:0]    req,
                                                  input logic [NR*PW-1:0] pri,
                                                  input logic [NR-1:0]    mask);
    int start;
    int idx;
    int cur_pri;
    int best_idx;
    int best_pri;
    start = 0;
    for (int i = 0; i < NR; i++) begin
      if (mask[i]) begin
        start = i + 1;
      end
    end
    // A full mask means the top index went last, so index 0 is next
    start = start % NR;
    best_idx = -1;
    best_pri = -1;
    for (int k = 0; k < NR; k++) begin
      idx = (start + k) % NR;
      cur_pri = int'(pri[idx*PW +: PW]);
      // Strictly greater keeps the earliest index in rotation order
      if (req[idx] && (cur_pri > best_pri)) begin
        best_pri = cur_pri;
        best_idx = idx;
      end
    end
    if (best_idx < 0) begin
      return '0;
    end
    return {1'b1, IW'(best_idx)};
  endfunction

  // The winner and every index below it have had their turn
  function automatic logic [NR-1:0] mask_after_grant(input logic [IW-1:0] winner);
    logic [NR-1:0] m;
    for (int i = 0; i < NR; i++) begin
      m[i] = (i <= int'(winner));
    end
    return m;
  endfunction

  function automatic logic [NR*PW-1:0] pack_priorities(input int p0, input int p1,
                                                       input int p2, input int p3);
    logic [NR*PW-1:0] packed_pri;
    packed_pri = '0;
    packed_pri[0*PW +: PW] = PW'(p0);
    packed_pri[1*PW +: PW] = PW'(p1);
    packed_pri[2*PW +: PW] = PW'(p2);
    packed_pri[3*PW +: PW] = PW'(p3);
    return packed_pri;
  endfunction

  // Distinct payload per slot so a wrong mux select shows up
  function automatic logic [DBW-1:0] slot_pattern(input int base);
    logic [DBW-1:0] d;
    for (int j = 0; j < NR; j++) begin
      d[j*DW +: DW] = DW'(base + 17 * j);
    end
    return d;
  endfunction

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------

  // Drives one cycle on the falling edge and queues what the output
  // stage must show after the next rising edge
  task automatic apply_cycle(input string            name,
                             input logic             en,
                             input logic [NR-1:0]    req,
                             input logic [NR*PW-1:0] pri,
                             input logic [DBW-1:0]   data);
    logic [IW:0] winner;
    int          win_idx;
    @(negedge clk);
    enable_priority_update = en;
    request                = req;
    request_priority       = pri;
    request_data           = data;
    winner  = expected_winner(req, pri, model_mask);
    win_idx = int'(winner[IW-1:0]);
    exp_valid_q.push_back(winner[IW]);
    exp_index_q.push_back(winner[IW-1:0]);
    exp_data_q.push_back(winner[IW] ? data[win_idx*DW +: DW] : '0);
    exp_name_q.push_back(name);
    // The hardware order only moves on a granted cycle with the enable high
    if (winner[IW] && en) begin
      model_mask = mask_after_grant(winner[IW-1:0]);
    end
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    logic [31:0] rnd_data;
    int          wait_cycles;
    int          assert_errors;
    seed                   = RANDOM_SEED;
    rst_n                  = 1'b0;
    enable_priority_update = 1'b0;
    request                = '0;
    request_priority       = '0;
    request_data           = '0;
    model_mask             = '0;

    repeat (4) @(posedge clk);
    @(negedge clk);
    assert (out_valid === 1'b0) else begin
      $display("CHECK FAILED reset_idle out_valid expected 0 actual %0b", out_valid);
      setup_errors++;
    end
    rst_n = 1'b1;

    repeat (3) apply_cycle("reset_idle", 1'b1, '0, '0, '0);

    // Each index alone, followed by an idle cycle
    for (int i = 0; i < NR; i++) begin
      apply_cycle("single_requester", 1'b1, NR'(1 << i), pack_priorities(i, 3 - i, 1, 2),
                  slot_pattern(32 + 3 * i));
      apply_cycle("single_idle", 1'b1, '0, '0, '0);
    end

    // Requester 1 wins twice, the second time while masked
    apply_cycle("strict_priority", 1'b1, 4'b1111, pack_priorities(1, 3, 0, 2), slot_pattern(64));
    apply_cycle("strict_priority", 1'b1, 4'b1111, pack_priorities(1, 3, 0, 2), slot_pattern(70));
    apply_cycle("strict_priority", 1'b1, 4'b1101, pack_priorities(2, 3, 0, 2), slot_pattern(80));
    apply_cycle("strict_priority", 1'b1, 4'b1001, pack_priorities(2, 0, 0, 2), slot_pattern(90));
    apply_cycle("strict_priority", 1'b1, 4'b0110, pack_priorities(0, 1, 3, 0), slot_pattern(100));
    apply_cycle("strict_priority", 1'b1, 4'b0011, pack_priorities(3, 2, 0, 0), slot_pattern(110));

    // Grant the top index first so the rotation starts at 0
    apply_cycle("round_robin_tie", 1'b1, 4'b1000, pack_priorities(1, 1, 1, 1), slot_pattern(120));
    repeat (8) begin
      apply_cycle("round_robin_tie", 1'b1, 4'b1111, pack_priorities(1, 1, 1, 1),
                  slot_pattern(130));
    end

    // Same winner while frozen, rotation moves on once enabled
    repeat (6) begin
      apply_cycle("frozen_state", 1'b0, 4'b1111, pack_priorities(2, 2, 2, 2), slot_pattern(144));
    end
    repeat (5) begin
      apply_cycle("frozen_resume", 1'b1, 4'b1111, pack_priorities(2, 2, 2, 2), slot_pattern(150));
    end
    apply_cycle("frozen_idle", 1'b1, '0, '0, '0);

    // Random requests, priorities, payloads and enable, enable mostly high
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      rnd      = $random(seed);
      rnd_data = $random(seed);
      apply_cycle("random_traffic", rnd[13:12] != 2'b00, rnd[NR-1:0], rnd[NR+NR*PW-1:NR],
                  rnd_data);
    end
    apply_cycle("final_idle", 1'b1, '0, '0, '0);

    // Let the compare process empty the queue
    wait_cycles = 0;
    while ((exp_valid_q.size() > 0) && (wait_cycles < DRAIN_TIMEOUT)) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (exp_valid_q.size() > 0) begin
      $display("ERROR: %0d queued results were never compared", exp_valid_q.size());
      setup_errors++;
    end

    // Property failures of the bound arbiter checker
    assert_errors = i_dut.i_arbiter.i_arb_checker.fail_count;

    $display("Checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
             check_count, value_errors, setup_errors, assert_errors);
    if ((value_errors == 0) && (setup_errors == 0) && (assert_errors == 0) &&
        (check_count > 0)) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // ------------------------------------------------
  // Comparison
  // ------------------------------------------------

  // Outputs are read just after the rising edge, once they have settled
  initial begin : compare_outputs
    int            wait_cycles;
    logic          exp_v;
    logic [IW-1:0] exp_i;
    logic [DW-1:0] exp_d;
    string         name;
    logic          have_last;
    logic [IW-1:0] last_i;
    logic [DW-1:0] last_d;
    wait_cycles = 0;
    have_last   = 1'b0;
    last_i      = '0;
    last_d      = '0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > RESET_TIMEOUT) begin
        $display("ERROR: reset was not released within %0d cycles", RESET_TIMEOUT);
        $display("Simulation finished: FAIL");
        $finish;
      end
    end
    forever begin
      @(posedge clk);
      #1;
      if (exp_valid_q.size() > 0) begin
        exp_v = exp_valid_q.pop_front();
        exp_i = exp_index_q.pop_front();
        exp_d = exp_data_q.pop_front();
        name  = exp_name_q.pop_front();
        check_count++;
        assert (out_valid === exp_v) else begin
          $display("CHECK FAILED %s out_valid expected %0b actual %0b", name, exp_v, out_valid);
          value_errors++;
        end
        if (exp_v) begin
          assert (out_index === exp_i) else begin
            $display("CHECK FAILED %s out_index expected %0d actual %0d", name, exp_i, out_index);
            value_errors++;
          end
          assert (out_data === exp_d) else begin
            $display("CHECK FAILED %s out_data expected %h actual %h", name, exp_d, out_data);
            value_errors++;
          end
          last_i    = exp_i;
          last_d    = exp_d;
          have_last = 1'b1;
        end else if (have_last) begin
          // Without a strobe the index and payload keep the last winner
          assert (out_index === last_i) else begin
            $display("CHECK FAILED %s held out_index expected %0d actual %0d",
                     name, last_i, out_index);
            value_errors++;
          end
          assert (out_data === last_d) else begin
            $display("CHECK FAILED %s held out_data expected %h actual %h",
                     name, last_d, out_data);
            value_errors++;
          end
        end
      end
    end
  end

endmodule : arb_top_tb

`default_nettype wire

// ==== bench/arb_checker.sv ====
// Samples the combinational grant on each rising edge, all properties are off while rst_n is low
`timescale 1ns/1ps
`default_nettype none

module arb_checker (
  input logic                                                  clk,
  input logic                                                  rst_n,
  input logic                                                  enable_priority_update,
  input logic [arb_pkg::NUM_REQUESTERS-1:0]                    request,
  input logic [arb_pkg::NUM_REQUESTERS*arb_pkg::PRI_WIDTH-1:0] request_priority,
  input logic [arb_pkg::NUM_REQUESTERS-1:0]                    grant
);

  // Number of property failures so far
  int fail_count = 0;

  // ------------------------------------------------
  // Grant shape
  // ------------------------------------------------

  // There is never more than one winner
  a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant))
    else begin
      $error("grant has more than one bit set: %b", grant);
      fail_count++;
    end

  // Any active request must produce a winner in the same cycle
  a_grant_on_request: assert property (@(posedge clk) disable iff (!rst_n)
    (|request) |-> (|grant))
    else begin
      $error("requests %b present but no grant", request);
      fail_count++;
    end

  // Only an active requester can win
  a_grant_subset: assert property (@(posedge clk) disable iff (!rst_n)
    ((grant & ~request) == '0))
    else begin
      $error("grant %b outside request %b", grant, request);
      fail_count++;
    end

  // ------------------------------------------------
  // Frozen round-robin state
  // ------------------------------------------------

  // With the enable low last cycle the mask held, so identical inputs
  // must give the identical grant
  a_grant_repeat: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(rst_n) && !$past(enable_priority_update) &&
     (request == $past(request)) &&
     (request_priority == $past(request_priority)))
    |-> (grant == $past(grant)))
    else begin
      $error("grant changed from %b to %b while the state was frozen",
             $past(grant), grant);
      fail_count++;
    end

endmodule : arb_checker

// Attach to every arbiter instance
bind pri_rr_arbiter arb_checker i_arb_checker (
  .clk                    (clk),
  .rst_n                  (rst_n),
  .enable_priority_update (enable_priority_update),
  .request                (request),
  .request_priority       (request_priority),
  .grant                  (grant)
);

`default_nettype wire

// ==== bench/tb_clock.sv ====
// Free-running 100 ns clock that starts low and never stops, so the bench must end the run itself
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // Half of the 100 ns period
  localparam int HALF_PERIOD = 50;

  initial begin
    clk = 1'b0;
  end

  // First rising edge at 50 ns, falling edges on whole periods
  always #HALF_PERIOD clk = ~clk;

endmodule : tb_clock

`default_nettype wire

// ==== hdl/arb_top.sv ====
// No back-pressure, a request in one cycle gives its result on the next edge and cannot be stalled
`timescale 1ns/1ps
`default_nettype none

module arb_top (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  enable_priority_update,
  input  logic [arb_pkg::NUM_REQUESTERS-1:0]                    request,
  input  logic [arb_pkg::NUM_REQUESTERS*arb_pkg::PRI_WIDTH-1:0] request_priority,
  input  logic [payload_pkg::DATA_BUS_WIDTH-1:0]                request_data,
  output logic                                                  out_valid,
  output logic [arb_pkg::IDX_WIDTH-1:0]                         out_index,
  output logic [payload_pkg::DATA_WIDTH-1:0]                    out_data
);

  // ------------------------------------------------
  // Arbitration
  // ------------------------------------------------

  // One-hot winner of the current cycle
  logic [arb_pkg::NUM_REQUESTERS-1:0] grant;

  // The arbiter holds its own round-robin state internally
  pri_rr_arbiter i_arbiter (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .enable_priority_update (enable_priority_update),
    .request                (request),
    .request_priority       (request_priority),
    .grant                  (grant)
  );

  // ------------------------------------------------
  // Registered output
  // ------------------------------------------------

  // Payload is picked from the same cycle's request data
  grant_register i_grant_register (
    .clk          (clk),
    .rst_n        (rst_n),
    .grant        (grant),
    .request_data (request_data),
    .out_valid    (out_valid),
    .out_index    (out_index),
    .out_data     (out_data)
  );

endmodule : arb_top

`default_nettype wire

// ==== hdl/grant_register.sv ====
// Expects a one-hot or zero grant, out_index and out_data are only meaningful while out_valid is high
`timescale 1ns/1ps
`default_nettype none

module grant_register (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [arb_pkg::NUM_REQUESTERS-1:0]    grant,
  input  logic [payload_pkg::DATA_BUS_WIDTH-1:0] request_data,
  output logic                                  out_valid,
  output logic [arb_pkg::IDX_WIDTH-1:0]         out_index,
  output logic [payload_pkg::DATA_WIDTH-1:0]    out_data
);

  localparam int NR = arb_pkg::NUM_REQUESTERS;
  localparam int DW = payload_pkg::DATA_WIDTH;

  // ------------------------------------------------
  // Encode and select
  // ------------------------------------------------

  logic                          any_grant;
  logic [arb_pkg::IDX_WIDTH-1:0] grant_index;
  logic [DW-1:0]                 grant_data;

  assign any_grant = |grant;

  // With a one-hot grant exactly one term contributes, so ORing the
  // index and payload of every granted slot is an encoder and a mux
  always_comb begin
    grant_index = '0;
    grant_data  = '0;
    for (int i = 0; i < NR; i++) begin
      if (grant[i]) begin
        grant_index |= arb_pkg::IDX_WIDTH'(i);
        grant_data  |= request_data[i*DW +: DW];
      end
    end
  end

  // ------------------------------------------------
  // Output stage
  // ------------------------------------------------

  // One-cycle strobe, low again after any cycle without a grant
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= any_grant;
    end
  end

  // Index and payload only load on a grant and otherwise keep the
  // last winner
  always_ff @(posedge clk) begin
    if (any_grant) begin
      out_index <= grant_index;
      out_data  <= grant_data;
    end
  end

endmodule : grant_register

`default_nettype wire

// ==== hdl/pri_rr_arbiter.sv ====
// Combinational grant with zero latency, priority fields of inactive requesters are ignored
`timescale 1ns/1ps
`default_nettype none

module pri_rr_arbiter (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  enable_priority_update,
  input  logic [arb_pkg::NUM_REQUESTERS-1:0]                    request,
  input  logic [arb_pkg::NUM_REQUESTERS*arb_pkg::PRI_WIDTH-1:0] request_priority,
  output logic [arb_pkg::NUM_REQUESTERS-1:0]                    grant
);

  localparam int NR = arb_pkg::NUM_REQUESTERS;
  localparam int NP = arb_pkg::NUM_PRIORITIES;
  localparam int PW = arb_pkg::PRI_WIDTH;

  // Total bits once all levels are laid end to end
  localparam int FLAT_WIDTH = (NP + 1) * NR;

  // ------------------------------------------------
  // Round-robin state
  // ------------------------------------------------

  logic          update_priority;
  logic [NR-1:0] priority_mask;

  // The order only advances when a grant is actually made
  assign update_priority = enable_priority_update && (|request);

  rr_state i_rr_state (
    .clk             (clk),
    .rst_n           (rst_n),
    .update_priority (update_priority),
    .grant           (grant),
    .priority_mask   (priority_mask)
  );

  // ------------------------------------------------
  // Unrolled request levels
  // ------------------------------------------------

  // Level 0 holds the most urgent requests and level NP the least
  // An unmasked request of priority q sits at level NP-1-q
  // A masked request of priority q sits one level lower, at NP-q
  // Each level is filled as a thermometer, so a request present at
  // level p is also present at every level below it
  // Masked bits always have lower indices than unmasked ones, so
  // within one level a masked higher-priority request still comes
  // before an unmasked lower-priority one in index order
  logic [NP:0][NR-1:0] request_unrolled;

  // Every active request appears at the bottom level
  assign request_unrolled[NP] = request;

  for (genvar i = 0; i < NR; i++) begin : gen_unroll_req
    logic [PW-1:0] pri;

    assign pri = request_priority[i*PW +: PW];

    for (genvar p = 0; p < NP; p++) begin : gen_unroll_level
      if (p == 0) begin : gen_top
        // Only the highest priority, and only if still unmasked
        assign request_unrolled[p][i] = request[i] && !priority_mask[i] &&
                                        (pri == PW'(NP - 1));
      end else if (p == NP - 1) begin : gen_last
        // Any unmasked request, or a masked one above priority 0
        assign request_unrolled[p][i] = request[i] &&
                                        (!priority_mask[i] || (pri != '0));
      end else begin : gen_mid
        assign request_unrolled[p][i] = request[i] && (
            (!priority_mask[i] && (pri >= PW'(NP - 1 - p))) ||
            (priority_mask[i] && (pri >= PW'(NP - p))));
      end
    end
  end

  // ------------------------------------------------
  // Fixed priority pick over the flattened levels
  // ------------------------------------------------

  // Bit p*NR+i of the flat vector is requester i at level p
  // The lowest set bit is the winner
  logic [FLAT_WIDTH-1:0] request_flat;
  logic [FLAT_WIDTH-1:0] any_higher_req;
  logic [FLAT_WIDTH-1:0] grant_flat;

  assign request_flat = request_unrolled;

  // Running OR of everything below each position
  always_comb begin
    any_higher_req[0] = 1'b0;
    for (int k = 1; k < FLAT_WIDTH; k++) begin
      any_higher_req[k] = any_higher_req[k-1] | request_flat[k-1];
    end
  end

  // At most one flat bit survives
  assign grant_flat = request_flat & ~any_higher_req;

  // ------------------------------------------------
  // Fold the levels back to one grant per requester
  // ------------------------------------------------

  // Only one level carries a set bit, so an OR gives the one-hot grant
  always_comb begin
    grant = '0;
    for (int p = 0; p <= NP; p++) begin
      grant |= grant_flat[p*NR +: NR];
    end
  end

endmodule : pri_rr_arbiter

`default_nettype wire

// ==== hdl/rr_state.sv ====
// Grant must be one-hot whenever update_priority is high, a zero grant on update clears the mask
`timescale 1ns/1ps
`default_nettype none

module rr_state (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                update_priority,
  input  logic [arb_pkg::NUM_REQUESTERS-1:0]  grant,
  output logic [arb_pkg::NUM_REQUESTERS-1:0]  priority_mask
);

  // ------------------------------------------------
  // Next mask from the current grant
  // ------------------------------------------------

  // A set bit means that index has already had its turn in the
  // current round and drops below the unmasked requesters of the
  // same priority
  logic [arb_pkg::NUM_REQUESTERS-1:0] mask_from_grant;

  // Thermometer fill of the one-hot grant
  // Bit i is set when the granted index is i or higher, so the granted
  // requester and everything below it lose round-robin precedence
  always_comb begin
    mask_from_grant = '0;
    for (int i = 0; i < arb_pkg::NUM_REQUESTERS; i++) begin
      for (int j = i; j < arb_pkg::NUM_REQUESTERS; j++) begin
        if (grant[j]) begin
          mask_from_grant[i] = 1'b1;
        end
      end
    end
  end

  // When the granted index is the top one the mask comes out all ones
  // That is still correct: every requester is masked equally, so the
  // arbiter falls back to index order starting at 0, which is the
  // successor of the top index

  // ------------------------------------------------
  // Mask register
  // ------------------------------------------------

  // After reset nothing is masked, so index 0 leads the first round
  // The mask only moves on a cycle with update_priority high
  // With the enable low the mask holds and identical requests
  // keep producing the identical grant
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      priority_mask <= '0;
    end else if (update_priority) begin
      priority_mask <= mask_from_grant;
    end
  end

endmodule : rr_state

`default_nettype wire

// ==== hdl/payload_pkg.sv ====
// Payload format only, the requester count comes from arb_pkg which must be compiled first
`default_nettype none

// ------------------------------------------------
// Payload format carried through the output stage
// ------------------------------------------------
package payload_pkg;

  // Payload bits presented by each requester
  localparam int DATA_WIDTH = 8;

  // Flattened payload bus, requester i sits in slice i
  localparam int DATA_BUS_WIDTH = arb_pkg::NUM_REQUESTERS * DATA_WIDTH;

endpackage : payload_pkg

`default_nettype wire

// ==== hdl/arb_pkg.sv ====
// Counts are fixed at elaboration and both must be powers of two of at least 2 so derived widths are exact
`default_nettype none

// ------------------------------------------------
// Arbitration geometry shared by the RTL and the bench
// ------------------------------------------------
package arb_pkg;

  // Number of requesters on the shared bus
  localparam int NUM_REQUESTERS = 4;

  // Number of priority levels
  // Zero is the lowest level and NUM_PRIORITIES-1 the highest
  localparam int NUM_PRIORITIES = 4;

  // Bits per priority field in the flattened priority bus
  localparam int PRI_WIDTH = $clog2(NUM_PRIORITIES);

  // Bits of an encoded requester index
  localparam int IDX_WIDTH = $clog2(NUM_REQUESTERS);

endpackage : arb_pkg

`default_nettype wire
